/* uart_link.f */
hw/uart_pkg.sv
hw/uart_byte_fifo.sv
hw/uart_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_rx_buffer.sv
hw/uart_link.sv
tb/tb_uart_link.sv

/* Makefile */
# Verilator flow for uart_link

TOP := tb_uart_link

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f uart_link.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f uart_link.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* tb/tb_uart_link.sv */
// testbench for uart_link
// loops txd back to rxd or injects frames by hand, then checks data order,
// credit flow, bit timing, overrun and framing errors

`timescale 1ns/1ns

module tb_uart_link;

    import uart_pkg::*;

    localparam int BIT_CYC   = TICK_DIV * OVERSAMPLE;
    localparam int FRAME_CYC = FRAME_BITS * BIT_CYC;
    localparam int WAIT_MAX  = 20 * FRAME_CYC;

    logic          clk = 1'b0;
    logic          reset;
    logic          tx_push;
    uart_byte_t    tx_data;
    logic          tx_credit;
    logic          txd;
    logic          rxd_line;
    logic          rx_credit;
    logic          rx_valid;
    uart_rx_beat_t rx_beat;
    logic          overrun;

    // line selector between loopback and hand-driven frames
    logic          inj_mode;
    logic          inj_rxd;
    // reference state
    uart_rx_beat_t exp_q[$];
    uart_rx_beat_t exp_head;
    int            exp_cnt;
    int            rd_idx;
    int            host_credits;
    int            model_credits;
    int            push_total;
    int            credit_total;
    // txd frame monitor
    logic          txd_q;
    logic          txd_edge;
    logic          in_frame;
    logic          rise_seen;
    int            pos;
    int            start_len;
    int            frames_seen;
    logic          quiet;
    logic          overrun_ok;
    int            check_errs = 0;
    int            end_errs = 0;
    int            timeouts = 0;

    always #2 clk = ~clk;

    assign rxd_line = inj_mode ? inj_rxd : txd;
    assign txd_edge = (txd != txd_q);

    uart_link i_dut (
        .clk       (clk),
        .reset     (reset),
        .tx_push   (tx_push),
        .tx_data   (tx_data),
        .tx_credit (tx_credit),
        .txd       (txd),
        .rxd       (rxd_line),
        .rx_credit (rx_credit),
        .rx_valid  (rx_valid),
        .rx_beat   (rx_beat),
        .overrun   (overrun)
    );

    // --------------------------------------------------
    // reference model and txd monitor
    // --------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            host_credits  <= TX_DEPTH;
            model_credits <= 0;
            push_total    <= 0;
            credit_total  <= 0;
            rd_idx        <= 0;
            txd_q         <= 1'b1;
            in_frame      <= 1'b0;
            rise_seen     <= 1'b0;
            pos           <= 0;
            start_len     <= 0;
            frames_seen   <= 0;
        end else begin
            host_credits  <= host_credits + (tx_credit ? 1 : 0) - (tx_push ? 1 : 0);
            model_credits <= model_credits + (rx_credit ? 1 : 0) - (rx_valid ? 1 : 0);
            push_total    <= push_total + (tx_push ? 1 : 0);
            credit_total  <= credit_total + (tx_credit ? 1 : 0);
            if (rx_valid && rd_idx < exp_q.size()) begin
                rd_idx <= rd_idx + 1;
            end
            txd_q <= txd;
            // pos counts cycles since the start edge of the current frame
            if (txd_edge && !txd && (!in_frame || pos == FRAME_CYC)) begin
                in_frame    <= 1'b1;
                pos         <= 1;
                rise_seen   <= 1'b0;
                frames_seen <= frames_seen + 1;
            end else if (in_frame) begin
                if (pos == FRAME_CYC) begin
                    in_frame <= 1'b0;
                end else begin
                    pos <= pos + 1;
                end
                if (txd_edge && txd && !rise_seen) begin
                    rise_seen <= 1'b1;
                    start_len <= pos;
                end
            end
        end
    end

    // head of the expected stream is refreshed between edges
    always @(negedge clk) begin
        exp_cnt  = exp_q.size() - rd_idx;
        exp_head = (exp_cnt > 0) ? exp_q[rd_idx] : '0;
    end

    // --------------------------------------------------
    // assertions
    // --------------------------------------------------
    a_reset_state: assert property (@(posedge clk) disable iff (reset)
        quiet |-> (txd && !rx_valid && !tx_credit && !overrun))
        else begin
            check_errs++;
            $display("FAILED reset state: txd=%h rx_valid=%h tx_credit=%h overrun=%h",
                     $sampled(txd), $sampled(rx_valid), $sampled(tx_credit),
                     $sampled(overrun));
        end

    a_beat_expected: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> (exp_cnt != 0))
        else begin
            check_errs++;
            $display("beat delivered on rx_beat while no beat was expected");
        end

    a_beat_value: assert property (@(posedge clk) disable iff (reset)
        (rx_valid && exp_cnt != 0) |-> (rx_beat == exp_head))
        else begin
            check_errs++;
            $display("FAILED rx_beat: got %h expected %h", $sampled(rx_beat),
                     $sampled(exp_head));
        end

    a_rx_credit: assert property (@(posedge clk) disable iff (reset)
        rx_valid |-> (model_credits != 0))
        else begin
            check_errs++;
            $display("beat delivered without an outstanding receive credit");
        end

    a_credit_bound: assert property (@(posedge clk) disable iff (reset)
        host_credits <= TX_DEPTH)
        else begin
            check_errs++;
            $display("FAILED tx_credit: host credit count %h exceeds %h",
                     $sampled(host_credits), TX_DEPTH);
        end

    // the credit comes back in the cycle the start bit begins
    a_credit_edge: assert property (@(posedge clk) disable iff (reset)
        tx_credit |-> (!txd && txd_q))
        else begin
            check_errs++;
            $display("FAILED txd at tx_credit: got %h expected 0, previous %h expected 1",
                     $sampled(txd), $sampled(txd_q));
        end

    a_bit_edge: assert property (@(posedge clk) disable iff (reset)
        txd_edge |-> (in_frame ? (pos % BIT_CYC == 0) : !txd))
        else begin
            check_errs++;
            $display("txd changed off a bit boundary, %0d cycles into the frame",
                     $sampled(pos));
        end

    a_overrun: assert property (@(posedge clk) disable iff (reset)
        overrun |-> overrun_ok)
        else begin
            check_errs++;
            $display("FAILED overrun: got %h expected %h", $sampled(overrun),
                     $sampled(overrun_ok));
        end

    // --------------------------------------------------
    // stimulus tasks start and end 1 ns after a rising edge
    // --------------------------------------------------
    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic push_byte(input uart_byte_t b, input logic keep);
        uart_rx_beat_t beat;
        int            n;
        n = 0;
        while (host_credits == 0 && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (host_credits == 0) begin
            report_timeout("a transmit credit");
        end else begin
            tx_push = 1'b1;
            tx_data = b;
            if (keep) begin
                beat.frame_err = 1'b0;
                beat.data      = b;
                exp_q.push_back(beat);
            end
            @(posedge clk);
            #1;
            tx_push = 1'b0;
        end
    endtask

    task automatic grant_one;
        rx_credit = 1'b1;
        @(posedge clk);
        #1;
        rx_credit = 1'b0;
    endtask

    task automatic grant_credits(input int count);
        for (int i = 0; i < count; i++) begin
            grant_one();
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_valid;
        int n;
        n = 0;
        while (!rx_valid && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!rx_valid) begin
            report_timeout("a beat released by a credit");
        end
    endtask

    task automatic wait_drained;
        int n;
        n = 0;
        while (rd_idx != exp_q.size() && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (rd_idx != exp_q.size()) begin
            report_timeout("all expected beats on rx_beat");
        end
    endtask

    // all credits home and the last frame finished on txd
    task automatic wait_line_idle;
        int n;
        n = 0;
        while (!(host_credits == TX_DEPTH && !in_frame) && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!(host_credits == TX_DEPTH && !in_frame)) begin
            report_timeout("the transmitter to go idle");
        end
    endtask

    task automatic inject_frame(input uart_byte_t b, input logic stop_bit);
        logic [FRAME_BITS-1:0] frame;
        frame    = {stop_bit, b, 1'b0};
        inj_mode = 1'b1;
        for (int i = 0; i < FRAME_BITS; i++) begin
            inj_rxd = frame[i];
            repeat (BIT_CYC) @(posedge clk);
            #1;
        end
        inj_rxd = 1'b1;
    endtask

    // --------------------------------------------------
    // test sequences
    // --------------------------------------------------
    task automatic run_isolated_byte;
        grant_credits(1);
        // bit 0 is set so the first low run is the start bit alone
        push_byte(8'h5b, 1'b1);
        wait_drained();
        assert (start_len == BIT_CYC)
            else begin
                end_errs++;
                $display("FAILED start bit length: got %h expected %h", start_len, BIT_CYC);
            end
    endtask

    task automatic run_loopback;
        logic [31:0] r;
        grant_credits(12);
        for (int i = 0; i < 12; i++) begin
            r = $urandom();
            push_byte(r[7:0], 1'b1);
        end
        wait_drained();
    endtask

    task automatic run_framing_error;
        uart_rx_beat_t beat;
        grant_credits(2);
        beat.frame_err = 1'b1;
        beat.data      = 8'h3c;
        exp_q.push_back(beat);
        // rx goes idle mid stop bit and the rest of the low stop bit reads
        // as a new start edge; the high line after it gives 0xff with a good stop
        beat.frame_err = 1'b0;
        beat.data      = 8'hff;
        exp_q.push_back(beat);
        inject_frame(8'h3c, 1'b0);
        wait_drained();
        inj_mode = 1'b0;
    endtask

    task automatic run_backpressure;
        logic [31:0] r;
        int          base_frames;
        int          n;
        base_frames = frames_seen;
        for (int i = 0; i < RX_DEPTH + 2; i++) begin
            r = $urandom();
            push_byte(r[7:0], i < RX_DEPTH);
        end
        // overrun may rise only once the first extra byte is on the line
        n = 0;
        while (frames_seen - base_frames <= RX_DEPTH && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (frames_seen - base_frames <= RX_DEPTH) begin
            report_timeout("the first frame beyond the receive FIFO depth");
        end
        overrun_ok = 1'b1;
        wait_line_idle();
        assert (overrun == 1'b1)
            else begin
                end_errs++;
                $display("FAILED overrun: got %h expected 1", overrun);
            end
        for (int i = 0; i < RX_DEPTH; i++) begin
            grant_one();
            wait_valid();
        end
        // spare credits must not release the dropped bytes
        grant_credits(2);
        repeat (FRAME_CYC) @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(31));
        reset      = 1'b1;
        tx_push    = 1'b0;
        tx_data    = '0;
        rx_credit  = 1'b0;
        inj_mode   = 1'b0;
        inj_rxd    = 1'b1;
        quiet      = 1'b1;
        overrun_ok = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (BIT_CYC) @(posedge clk);
        #1;
        quiet = 1'b0;

        run_isolated_byte();
        run_loopback();
        run_framing_error();
        run_backpressure();
        wait_drained();
        assert (host_credits == TX_DEPTH && credit_total == push_total)
            else begin
                end_errs++;
                $display("FAILED tx_credit: host credits %h expected %h, pulses %h pushes %h",
                         host_credits, TX_DEPTH, credit_total, push_total);
            end

        $display("errors: %0d assertion, %0d end of test, %0d timeouts",
                 check_errs, end_errs, timeouts);
        if (check_errs == 0 && end_errs == 0 && timeouts == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* hw/uart_link.sv */
// uart_link top level
// full-duplex byte UART: tick generator, transmitter, receiver and the
// credit-gated receive buffer

`timescale 1ns/1ns

module uart_link (
    input  var logic                    clk,
    input  var logic                    reset,
    input  var logic                    tx_push,
    input  var uart_pkg::uart_byte_t    tx_data,
    output var logic                    tx_credit,
    output var logic                    txd,
    input  var logic                    rxd,
    input  var logic                    rx_credit,
    output var logic                    rx_valid,
    output var uart_pkg::uart_rx_beat_t rx_beat,
    output var logic                    overrun
);

    import uart_pkg::*;

    logic          tick;
    logic          rx_put;
    uart_rx_beat_t rx_word;

    // --------------------------------------------------
    // shared oversampling tick
    // --------------------------------------------------
    uart_tick_gen i_tick_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    // host to line
    uart_tx i_tx (
        .clk    (clk),
        .reset  (reset),
        .tick   (tick),
        .push   (tx_push),
        .data   (tx_data),
        .credit (tx_credit),
        .txd    (txd)
    );

    // --------------------------------------------------
    // line to consumer
    // --------------------------------------------------
    uart_rx i_rx (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .rxd   (rxd),
        .put   (rx_put),
        .word  (rx_word)
    );

    uart_rx_buffer i_rx_buffer (
        .clk     (clk),
        .reset   (reset),
        .put     (rx_put),
        .word    (rx_word),
        .credit  (rx_credit),
        .valid   (rx_valid),
        .beat    (rx_beat),
        .overrun (overrun)
    );

endmodule

/* hw/uart_rx_buffer.sv */
// receive buffer
// queues received beats, flags overrun on a full FIFO and releases one
// beat per credit granted by the consumer

`timescale 1ns/1ns

module uart_rx_buffer (
    input  var logic                    clk,
    input  var logic                    reset,
    input  var logic                    put,
    input  var uart_pkg::uart_rx_beat_t word,
    input  var logic                    credit,
    output var logic                    valid,
    output var uart_pkg::uart_rx_beat_t beat,
    output var logic                    overrun
);

    import uart_pkg::*;

    uart_rx_beat_t          fifo_beat;
    logic                   fifo_full;
    logic                   fifo_empty;
    logic [CREDIT_W-1:0]    credits;
    logic                   deliver;

    uart_byte_fifo #(
        .WIDTH ($bits(uart_rx_beat_t)),
        .DEPTH (RX_DEPTH)
    ) i_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (put && !fifo_full),
        .wr_data (word),
        .rd_en   (deliver),
        .rd_data (fifo_beat),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    assign deliver = !fifo_empty && (credits != '0);

    // --------------------------------------------------
    // credits, delivery and overrun
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= '0;
            valid   <= 1'b0;
            overrun <= 1'b0;
        end else begin
            valid <= deliver;
            // sticky until reset, the byte itself is lost
            if (put && fifo_full) begin
                overrun <= 1'b1;
            end
            // grant and delivery together cancel out; counter saturates
            if (credit && !deliver && credits != '1) begin
                credits <= credits + 1'b1;
            end else if (deliver && !credit) begin
                credits <= credits - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            beat <= fifo_beat;
        end
    end

endmodule

/* hw/uart_rx.sv */
// UART receiver
// 8x oversampling, start detected on the registered line, each bit taken
// at its middle sub-count; stop bit checked for framing

`timescale 1ns/1ns

module uart_rx (
    input  var logic                    clk,
    input  var logic                    reset,
    input  var logic                    tick,
    input  var logic                    rxd,
    output var logic                    put,
    output var uart_pkg::uart_rx_beat_t word
);

    import uart_pkg::*;

    logic                   rxd_q;
    rx_state_t              state;
    logic [SUB_W-1:0]       sub_cnt;
    logic [FRAME_IDX_W-1:0] bit_cnt;
    logic [DATA_BITS:0]     sample_sr;
    logic                   mid_bit;
    logic                   last_bit;

    assign mid_bit  = (state == RX_BUSY) && (sub_cnt == SUB_W'(MID_SAMPLE));
    assign last_bit = (bit_cnt == FRAME_IDX_W'(FRAME_BITS - 1));

    // stop sample is rxd_q itself, shift register holds data above start
    assign put            = tick && mid_bit && last_bit;
    assign word.data      = sample_sr[DATA_BITS:1];
    assign word.frame_err = ~rxd_q;

    // --------------------------------------------------
    // line sampling and bit counting
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rxd_q   <= 1'b1;
            state   <= RX_IDLE;
            sub_cnt <= '0;
            bit_cnt <= '0;
        end else if (tick) begin
            rxd_q <= rxd;
            case (state)
                RX_IDLE: begin
                    // falling edge on the line opens a frame
                    if (!rxd_q) begin
                        state   <= RX_BUSY;
                        sub_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                default: begin
                    if (sub_cnt == SUB_W'(OVERSAMPLE - 1)) begin
                        sub_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                    end else begin
                        sub_cnt <= sub_cnt + 1'b1;
                    end
                    if (mid_bit) begin
                        sample_sr <= {rxd_q, sample_sr[DATA_BITS:1]};
                        // back to idle mid stop bit, ready for the next edge
                        if (last_bit) begin
                            state <= RX_IDLE;
                        end
                    end
                end
            endcase
        end
    end

endmodule

/* hw/uart_tx.sv */
// UART transmitter
// byte FIFO in front of a start/data/stop serializer paced by the tick;
// every byte taken from the FIFO hands one credit back to the host

`timescale 1ns/1ns

module uart_tx (
    input  var logic                 clk,
    input  var logic                 reset,
    input  var logic                 tick,
    input  var logic                 push,
    input  var uart_pkg::uart_byte_t data,
    output var logic                 credit,
    output var logic                 txd
);

    import uart_pkg::*;

    uart_byte_t             fifo_data;
    logic                   fifo_full;
    logic                   fifo_empty;
    tx_state_t              state;
    logic [SUB_W-1:0]       sub_cnt;
    logic [DATA_IDX_W-1:0]  bit_idx;
    uart_byte_t             shift;
    logic                   bit_end;
    logic                   pop;

    uart_byte_fifo #(
        .WIDTH ($bits(uart_byte_t)),
        .DEPTH (TX_DEPTH)
    ) i_fifo (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (push && !fifo_full),
        .wr_data (data),
        .rd_en   (pop),
        .rd_data (fifo_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    assign bit_end = tick && (sub_cnt == SUB_W'(OVERSAMPLE - 1));

    // start from idle on any tick, or straight after a stop bit so that
    // back-to-back frames keep whole bit periods
    assign pop = !fifo_empty
              && ((state == TX_IDLE && tick) || (state == TX_STOP && bit_end));

    // --------------------------------------------------
    // serializer FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            sub_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
            credit  <= 1'b0;
        end else begin
            credit <= pop;
            if (pop) begin
                state   <= TX_START;
                sub_cnt <= '0;
                shift   <= fifo_data;
                txd     <= 1'b0;
            end else if (tick && state != TX_IDLE) begin
                sub_cnt <= bit_end ? '0 : sub_cnt + 1'b1;
                if (bit_end) begin
                    case (state)
                        TX_START: begin
                            txd     <= shift[0];
                            shift   <= {1'b0, shift[DATA_BITS-1:1]};
                            bit_idx <= '0;
                            state   <= TX_DATA;
                        end
                        TX_DATA: begin
                            if (bit_idx == DATA_IDX_W'(DATA_BITS - 1)) begin
                                txd   <= 1'b1;
                                state <= TX_STOP;
                            end else begin
                                txd     <= shift[0];
                                shift   <= {1'b0, shift[DATA_BITS-1:1]};
                                bit_idx <= bit_idx + 1'b1;
                            end
                        end
                        default: state <= TX_IDLE;
                    endcase
                end
            end
        end
    end

endmodule

/* hw/uart_tick_gen.sv */
// oversampling tick generator
// divides clk by TICK_DIV into a one-cycle tick for both serial directions

`timescale 1ns/1ns

module uart_tick_gen (
    input  var logic clk,
    input  var logic reset,
    output var logic tick
);

    import uart_pkg::*;

    logic [TICK_CNT_W-1:0] cnt;

    // down counter, tick fires the cycle after it reaches zero
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= TICK_CNT_W'(TICK_DIV - 1);
            tick <= 1'b0;
        end else begin
            tick <= (cnt == '0);
            if (cnt == '0) begin
                cnt <= TICK_CNT_W'(TICK_DIV - 1);
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

/* hw/uart_byte_fifo.sv */
// byte FIFO for the UART core
// single-clock circular buffer with occupancy count, full and empty flags;
// rd_data shows the head entry without a read strobe

`timescale 1ns/1ns

module uart_byte_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  var logic             clk,
    input  var logic             reset,
    input  var logic             wr_en,
    input  var logic [WIDTH-1:0] wr_data,
    input  var logic             rd_en,
    output var logic [WIDTH-1:0] rd_data,
    output var logic             full,
    output var logic             empty
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // writes to a full FIFO and reads from an empty one are ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // --------------------------------------------------
    // pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // explicit wrap so non power-of-two depths work
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* hw/uart_pkg.sv */
// uart_link shared definitions
// widths, FIFO depths, bit timing constants, FSM encodings and the
// receive beat carried from the receiver to the consumer

package uart_pkg;

    // --------------------------------------------------
    // bit timing
    // --------------------------------------------------
    // one bit lasts TICK_DIV * OVERSAMPLE clk cycles
    localparam int TICK_DIV    = 4;
    localparam int TICK_CNT_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam int OVERSAMPLE  = 8;
    localparam int SUB_W       = $clog2(OVERSAMPLE);
    // receiver samples each bit at this sub-count
    localparam int MID_SAMPLE  = 3;

    // --------------------------------------------------
    // frame layout and buffering
    // --------------------------------------------------
    localparam int DATA_BITS   = 8;
    localparam int DATA_IDX_W  = $clog2(DATA_BITS);
    // start + data + stop
    localparam int FRAME_BITS  = DATA_BITS + 2;
    localparam int FRAME_IDX_W = $clog2(FRAME_BITS);
    localparam int TX_DEPTH    = 4;
    localparam int RX_DEPTH    = 8;
    localparam int CREDIT_W    = $clog2(RX_DEPTH + 1);

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    typedef struct packed {
        logic       frame_err;
        uart_byte_t data;
    } uart_rx_beat_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;
    typedef enum logic {RX_IDLE, RX_BUSY} rx_state_t;

endpackage
